// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - hdl/pipe_pkg.sv
  - hdl/isa_pkg.sv
  - hdl/dec_if.sv
  - hdl/id_stage_reg.sv
  - hdl/inst_decoder.sv
  - hdl/issue_ctrl.sv
  - hdl/branch_unit.sv
  - hdl/exe_ctrl_gen.sv
  - hdl/decode_top.sv
  - target: simulation
    files:
      - dv/tb_decode.sv

// ==== dv/decode_golden.txt ====
// in:  pc inst rs_value rt_value exe_wdest mem_wdest wb_wdest if_over
// out: id_over jbr_taken jbr_target alu_control operand1 operand2 rf_wen rf_wdest mem_ctl ovf
// register alu: add subu slt sltu and nor xor (xor with if_over low)
00400000 00221820 00000005 00000007 00 00 00 1  1 0 00406084 800 00000005 00000007 1 03 0 1
00400004 00221823 0000000a 00000003 00 00 00 1  1 0 00406094 400 0000000a 00000003 1 03 0 0
00400008 0022182a ffffffff 00000001 00 00 00 1  1 0 004060b4 200 ffffffff 00000001 1 03 0 0
0040000c 0022182b ffffffff 00000001 00 00 00 1  1 0 004060bc 100 ffffffff 00000001 1 03 0 0
00400010 00221824 0000ff00 00000ff0 00 00 00 1  1 0 004060a4 080 0000ff00 00000ff0 1 03 0 0
00400014 00221827 0000ff00 00000ff0 00 00 00 1  1 0 004060b4 040 0000ff00 00000ff0 1 03 0 0
00400018 00221826 0000ff00 00000ff0 00 00 00 0  1 0 004060b4 010 0000ff00 00000ff0 1 03 0 0
// shifts: sll sa=5, sra sa=31, srlv
0040001c 00021940 12345678 0000000f 00 00 00 1  1 0 00406520 008 00000005 0000000f 1 03 0 0
00400020 00021fc3 12345678 80000000 00 00 00 1  1 0 00407f30 002 0000001f 80000000 1 03 0 0
00400024 00221806 00000004 80000000 00 00 00 1  1 0 00406040 004 00000004 80000000 1 03 0 0
// immediates: addi sltiu andi ori lui, then lw and sw (sw stalls on wb)
00400028 2022fffc 00000010 deadbeef 00 00 00 1  1 0 0040001c 800 00000010 fffffffc 1 02 0 1
0040002c 2c228000 00000001 00000000 00 00 00 1  1 0 003e0030 100 00000001 ffff8000 1 02 0 0
00400030 30228001 ffffffff 00000000 00 00 00 1  1 0 003e0038 080 ffffffff 00008001 1 02 0 0
00400034 3422ffff 00000000 00000000 00 00 00 1  1 0 00400034 020 00000000 0000ffff 1 02 0 0
00400038 3c021234 00000000 00000000 00 00 00 1  1 0 0040490c 001 00000000 00001234 1 02 0 0
0040003c 8c220008 10000000 00000000 00 00 00 1  1 0 00400060 800 10000000 00000008 1 02 5 0
00400040 ac22fff8 10000000 11111111 00 00 02 1  0 0 00400024 800 10000000 fffffff8 0 00 3 0
// jumps: j jal jr jalr
9fc00100 08100080 00000000 00000000 00 00 00 1  1 1 90400200 000 00000000 00000000 0 00 0 0
9fc00200 0c100040 00000000 00000000 00 00 00 1  1 1 90400100 800 9fc00200 00000008 1 1f 0 0
00400100 00200008 00400800 00000000 00 00 00 1  1 1 00400800 000 00400800 00000000 0 00 0 0
00400300 0020f809 00401000 00000000 00 00 00 1  1 1 00401000 800 00400300 00000008 1 1f 0 0
// branches, taken and not taken
00400400 10220010 00000005 00000005 00 00 00 1  1 1 00400444 000 00000005 00000005 0 00 0 0
00400500 1022fffe 00000005 00000006 00 00 00 1  1 0 004004fc 000 00000005 00000006 0 00 0 0
00400600 14220010 00000001 00000002 00 00 00 1  1 1 00400644 000 00000001 00000002 0 00 0 0
00401100 14220010 00000007 00000007 00 00 00 1  1 0 00401144 000 00000007 00000007 0 00 0 0
00400700 18200010 00000001 00000000 00 00 00 1  1 0 00400744 000 00000001 00000000 0 00 0 0
00400a00 18200010 80000000 00000000 00 00 00 1  1 1 00400a44 000 80000000 00000000 0 00 0 0
00400800 1c200010 00000003 00000000 00 00 00 1  1 1 00400844 000 00000003 00000000 0 00 0 0
00400900 1c20fffe 00000000 00000000 00 00 00 1  1 0 004008fc 000 00000000 00000000 0 00 0 0
00400b00 04200010 80000000 00000000 00 00 00 1  1 1 00400b44 000 80000000 00000000 0 00 0 0
00400c00 0420fffe 00000000 00000000 00 00 00 1  1 0 00400bfc 000 00000000 00000000 0 00 0 0
00400d00 04210010 00000000 00000000 00 00 00 1  1 1 00400d44 000 00000000 00000000 0 00 0 0
00400e00 0421fffe ffffffff 00000000 00 00 00 1  1 0 00400dfc 000 ffffffff 00000000 0 00 0 0
00400f00 04300010 ffffffff 00000000 00 00 00 1  1 1 00400f44 800 00400f00 00000008 1 1f 0 0
00401000 04310010 80000000 00000000 00 00 00 1  1 0 00401044 800 00401000 00000008 1 1f 0 0
// hazards: rs on exe, rt on mem, unread rt, register 0, unread j fields
00401200 00221822 00000009 00000004 01 00 00 1  0 0 0040728c 400 00000009 00000004 1 03 0 1
00401300 10220010 00000003 00000003 00 02 00 1  0 0 00401344 000 00000003 00000003 0 00 0 0
00401400 20220001 00000001 00000000 00 00 02 1  1 0 00401408 800 00000001 00000001 1 02 0 1
00401500 00001821 00000000 00000000 00 05 00 1  1 0 00407588 800 00000000 00000000 1 03 0 0
00401600 08220000 00000000 00000000 01 02 00 1  1 1 00880000 000 00000000 00000000 0 00 0 0
// branch held until fetch finishes
00401700 14220010 00000001 00000002 00 00 00 0  0 0 00401744 000 00000001 00000002 0 00 0 0

// ==== dv/tb_decode.sv ====
`timescale 1ns/1ps

module tb_decode import isa_pkg::*; import pipe_pkg::*; ();

    localparam int N_FIELDS = 18;               // 8 inputs, 10 expected outputs
    localparam int MAX_VEC  = 64;
    localparam int TIMEOUT  = 20;               // cycles per wait

    logic                  clk;
    logic                  arst_n;
    logic                  in_valid;
    logic [XLEN-1:0]       in_pc;
    logic [XLEN-1:0]       in_inst;
    logic [XLEN-1:0]       rs_value;
    logic [XLEN-1:0]       rt_value;
    reg_addr_t             exe_wdest;
    reg_addr_t             mem_wdest;
    reg_addr_t             wb_wdest;
    logic                  if_over;
    logic                  in_ready;
    reg_addr_t             rs;
    reg_addr_t             rt;
    logic                  id_over;
    logic                  rs_wait;
    logic                  rt_wait;
    logic                  jbr_taken;
    logic [XLEN-1:0]       jbr_target;
    logic [ALU_OPS-1:0]    alu_control;
    logic [XLEN-1:0]       alu_operand1;
    logic [XLEN-1:0]       alu_operand2;
    logic [XLEN-1:0]       store_data;
    logic                  check_overflow;
    logic [MEM_CTRL_W-1:0] mem_control;
    logic                  rf_wen;
    reg_addr_t             rf_wdest;

    logic [XLEN-1:0] golden [0:N_FIELDS*MAX_VEC-1]; // flat, one word per field
    int              n_vec;

    decode_top dut (
        .clk            (clk),
        .arst_n         (arst_n),
        .in_valid       (in_valid),
        .in_pc          (in_pc),
        .in_inst        (in_inst),
        .rs_value       (rs_value),
        .rt_value       (rt_value),
        .exe_wdest      (exe_wdest),
        .mem_wdest      (mem_wdest),
        .wb_wdest       (wb_wdest),
        .if_over        (if_over),
        .in_ready       (in_ready),
        .rs             (rs),
        .rt             (rt),
        .id_over        (id_over),
        .rs_wait        (rs_wait),
        .rt_wait        (rt_wait),
        .jbr_taken      (jbr_taken),
        .jbr_target     (jbr_target),
        .alu_control    (alu_control),
        .alu_operand1   (alu_operand1),
        .alu_operand2   (alu_operand2),
        .store_data     (store_data),
        .check_overflow (check_overflow),
        .mem_control    (mem_control),
        .rf_wen         (rf_wen),
        .rf_wdest       (rf_wdest)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check(input string name, input logic [XLEN-1:0] expected,
                         input logic [XLEN-1:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // a nonzero field that equals one of the later destinations of the vector
    function automatic logic dest_match(input logic [4:0] field, input int in_base);
        logic hit;
        hit = 1'b0;
        for (int k = 4; k <= 6; k++) begin
            hit = hit | ((field != '0) && (field == golden[in_base+k][4:0]));
        end
        return hit;
    endfunction

    // ***********************************************************
    // handshake waits, each bounded by its own timeout
    // ***********************************************************
    task automatic wait_for_ready(input int v);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!in_ready) begin
            if (cycles == TIMEOUT) begin
                $display("timeout: the stage never became ready for vector %0d", v);
                $display("Verification failed");
                $fatal(1);
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic wait_for_release(input int v);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!id_over) begin
            if (cycles == TIMEOUT) begin
                $display("timeout: vector %0d was never released by the stage", v);
                $display("Verification failed");
                $fatal(1);
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic apply_vector(input int v);
        int base;
        base = v * N_FIELDS;
        @(posedge clk);
        in_valid  <= 1'b1;
        in_pc     <= golden[base];
        in_inst   <= golden[base+1];
        rs_value  <= golden[base+2];
        rt_value  <= golden[base+3];
        exe_wdest <= golden[base+4][4:0];
        mem_wdest <= golden[base+5][4:0];
        wb_wdest  <= golden[base+6][4:0];
        if_over   <= golden[base+7][0];
        @(posedge clk);                         // capture edge
        in_valid  <= 1'b0;
    endtask

    task automatic compare_outputs(input int v);
        int    in_base;
        int    out_base;
        string tag;
        logic  stalled;
        logic  exp_rs_wait;
        logic  exp_rt_wait;
        in_base  = v * N_FIELDS;
        out_base = in_base + 8;
        tag      = $sformatf("vector %0d ", v);
        stalled  = ~golden[out_base][0];
        // a stall with a matching source is a hazard, otherwise fetch is late
        exp_rs_wait = stalled & dest_match(golden[in_base+1][25:21], in_base);
        exp_rt_wait = stalled & dest_match(golden[in_base+1][20:16], in_base);
        @(negedge clk);
        check({tag, "id_over"}, golden[out_base], id_over);
        check({tag, "in_ready"}, golden[out_base], in_ready); // held until it leaves
        check({tag, "jbr_taken"}, golden[out_base+1], jbr_taken);
        check({tag, "jbr_target"}, golden[out_base+2], jbr_target);
        check({tag, "alu_control"}, golden[out_base+3], alu_control);
        check({tag, "alu_operand1"}, golden[out_base+4], alu_operand1);
        check({tag, "alu_operand2"}, golden[out_base+5], alu_operand2);
        check({tag, "rf_wen"}, golden[out_base+6], rf_wen);
        check({tag, "rf_wdest"}, golden[out_base+7], rf_wdest);
        check({tag, "mem_control"}, golden[out_base+8], mem_control);
        check({tag, "check_overflow"}, golden[out_base+9], check_overflow);
        check({tag, "store_data"}, golden[in_base+3], store_data);
        check({tag, "rs"}, golden[in_base+1][25:21], rs);   // register file read ports
        check({tag, "rt"}, golden[in_base+1][20:16], rt);
        check({tag, "rs_wait"}, exp_rs_wait, rs_wait);
        check({tag, "rt_wait"}, exp_rt_wait, rt_wait);
    endtask

    task automatic release_stage(input int v);
        @(posedge clk);
        exe_wdest <= '0;                        // later stages drain
        mem_wdest <= '0;
        wb_wdest  <= '0;
        if_over   <= 1'b1;
        wait_for_release(v);
    endtask

    // ***********************************************************
    // main sequence
    // ***********************************************************
    initial begin
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_pc     = '0;
        in_inst   = '0;
        rs_value  = '0;
        rt_value  = '0;
        exe_wdest = '0;
        mem_wdest = '0;
        wb_wdest  = '0;
        if_over   = 1'b1;

        $readmemh("dv/decode_golden.txt", golden);
        n_vec = 0;
        while (n_vec < MAX_VEC && !$isunknown(golden[n_vec*N_FIELDS+1])
               && golden[n_vec*N_FIELDS+1] != '0) begin
            n_vec++;
        end

        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        for (int v = 0; v < n_vec; v++) begin
            wait_for_ready(v);
            apply_vector(v);
            compare_outputs(v);
            if (golden[v*N_FIELDS+8] == '0) begin
                release_stage(v);               // let the stalled vector drain
            end
        end

        if (n_vec == 0) begin
            $display("no test vectors could be read from dv/decode_golden.txt");
            $display("Verification failed");
            $fatal(1);
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// ==== flist.f ====
hdl/pipe_pkg.sv
hdl/isa_pkg.sv
hdl/dec_if.sv
hdl/id_stage_reg.sv
hdl/inst_decoder.sv
hdl/issue_ctrl.sv
hdl/branch_unit.sv
hdl/exe_ctrl_gen.sv
hdl/decode_top.sv
dv/tb_decode.sv

// ==== hdl/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit import isa_pkg::*; import pipe_pkg::*; (
    input  logic [XLEN-1:0] pc,
    input  inst_word_u      inst,
    input  logic [XLEN-1:0] rs_value,
    input  logic [XLEN-1:0] rt_value,
    input  logic            id_over,
    dec_if.branch           dec,
    output logic            jbr_taken,
    output logic [XLEN-1:0] jbr_target
);

    logic [XLEN-1:0] bd_pc;                     // delay slot pc
    logic [XLEN-1:0] j_target, br_target;
    logic            j_taken, br_taken;
    logic            rs_eq_rt, rs_ez, rs_ltz;

    assign bd_pc = pc + INST_BYTES;

    // ***********************************************************
    // unconditional jumps
    // ***********************************************************
    assign j_taken  = dec.jr | dec.j_abs;
    assign j_target = dec.jr ? rs_value
                             : {bd_pc[XLEN-1:XLEN-4], inst.j.target, 2'b00};

    // ***********************************************************
    // conditional branches
    // ***********************************************************
    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_ez    = (rs_value == '0);
    assign rs_ltz   = rs_value[XLEN-1];

    assign br_taken = dec.br_eq  &  rs_eq_rt
                    | dec.br_ne  & ~rs_eq_rt
                    | dec.br_gez & ~rs_ltz
                    | dec.br_gtz & ~rs_ltz & ~rs_ez
                    | dec.br_lez & (rs_ltz | rs_ez)
                    | dec.br_ltz &  rs_ltz;

    assign br_target = bd_pc + {{(XLEN-18){inst.i.imm[15]}}, inst.i.imm, 2'b00};

    assign jbr_taken  = (j_taken | br_taken) & id_over;
    assign jbr_target = j_taken ? j_target : br_target;

endmodule

// ==== hdl/dec_if.sv ====
`timescale 1ns/1ps

interface dec_if import pipe_pkg::*; ();

    logic [ALU_OPS-1:0] alu_class;               // one-hot, add not forced yet
    logic imm_zero, imm_sign, shf_sa;
    logic j_link, jr, j_abs;
    logic br_eq, br_ne, br_gez, br_gtz, br_lez, br_ltz;
    logic is_jbr;
    logic no_rs, no_rt;                         // field is not a source register
    logic wdest_rt, wdest_31, wdest_rd;
    logic load, store;

    modport decoder (
        output alu_class, imm_zero, imm_sign, shf_sa,
        output j_link, jr, j_abs,
        output br_eq, br_ne, br_gez, br_gtz, br_lez, br_ltz,
        output is_jbr, no_rs, no_rt,
        output wdest_rt, wdest_31, wdest_rd, load, store
    );

    modport branch (
        input jr, j_abs, br_eq, br_ne, br_gez, br_gtz, br_lez, br_ltz
    );

    modport hazard (input no_rs, no_rt, is_jbr);

    modport exe (
        input alu_class, imm_zero, imm_sign, shf_sa, j_link,
        input wdest_rt, wdest_31, wdest_rd, load, store
    );

endinterface

// ==== hdl/decode_top.sv ====
`timescale 1ns/1ps

module decode_top import isa_pkg::*; import pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  logic [XLEN-1:0]       in_pc,
    input  logic [XLEN-1:0]       in_inst,
    input  logic [XLEN-1:0]       rs_value,
    input  logic [XLEN-1:0]       rt_value,
    input  reg_addr_t             exe_wdest,
    input  reg_addr_t             mem_wdest,
    input  reg_addr_t             wb_wdest,
    input  logic                  if_over,
    output logic                  in_ready,
    output reg_addr_t             rs,
    output reg_addr_t             rt,
    output logic                  id_over,
    output logic                  rs_wait,
    output logic                  rt_wait,
    output logic                  jbr_taken,
    output logic [XLEN-1:0]       jbr_target,
    output logic [ALU_OPS-1:0]    alu_control,
    output logic [XLEN-1:0]       alu_operand1,
    output logic [XLEN-1:0]       alu_operand2,
    output logic [XLEN-1:0]       store_data,
    output logic                  check_overflow,
    output logic [MEM_CTRL_W-1:0] mem_control,
    output logic                  rf_wen,
    output reg_addr_t             rf_wdest
);

    localparam int N_WB_STAGES = 3;             // exe, mem, wb

    logic                        valid;
    logic [XLEN-1:0]             pc;
    inst_word_u                  inst;
    reg_addr_t [N_WB_STAGES-1:0] later_wdest;

    dec_if dec ();

    assign later_wdest = {exe_wdest, mem_wdest, wb_wdest};
    assign rs          = inst.r.rs;             // register file read addresses
    assign rt          = inst.r.rt;

    id_stage_reg #(.PC_W(XLEN)) u_stage_reg (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_pc    (in_pc),
        .in_inst  (in_inst),
        .id_over  (id_over),
        .in_ready (in_ready),
        .valid    (valid),
        .pc       (pc),
        .inst     (inst)
    );

    inst_decoder u_decoder (
        .inst (inst),
        .dec  (dec.decoder)
    );

    issue_ctrl #(.N_WB_STAGES(N_WB_STAGES)) u_issue (
        .valid   (valid),
        .if_over (if_over),
        .inst    (inst),
        .wdest   (later_wdest),
        .dec     (dec.hazard),
        .rs_wait (rs_wait),
        .rt_wait (rt_wait),
        .id_over (id_over)
    );

    branch_unit u_branch (
        .pc         (pc),
        .inst       (inst),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .id_over    (id_over),
        .dec        (dec.branch),
        .jbr_taken  (jbr_taken),
        .jbr_target (jbr_target)
    );

    exe_ctrl_gen u_exe_ctrl (
        .pc             (pc),
        .inst           (inst),
        .rs_value       (rs_value),
        .rt_value       (rt_value),
        .dec            (dec.exe),
        .alu_control    (alu_control),
        .alu_operand1   (alu_operand1),
        .alu_operand2   (alu_operand2),
        .store_data     (store_data),
        .check_overflow (check_overflow),
        .mem_control    (mem_control),
        .rf_wen         (rf_wen),
        .rf_wdest       (rf_wdest)
    );

endmodule

// ==== hdl/exe_ctrl_gen.sv ====
`timescale 1ns/1ps

module exe_ctrl_gen import isa_pkg::*; import pipe_pkg::*; (
    input  logic [XLEN-1:0]       pc,
    input  inst_word_u            inst,
    input  logic [XLEN-1:0]       rs_value,
    input  logic [XLEN-1:0]       rt_value,
    dec_if.exe                    dec,
    output logic [ALU_OPS-1:0]    alu_control,
    output logic [XLEN-1:0]       alu_operand1,
    output logic [XLEN-1:0]       alu_operand2,
    output logic [XLEN-1:0]       store_data,
    output logic                  check_overflow,
    output logic [MEM_CTRL_W-1:0] mem_control,
    output logic                  rf_wen,
    output reg_addr_t             rf_wdest
);

    logic force_add;

    assign force_add = dec.load | dec.store | dec.j_link; // address or pc + 8

    always_comb begin
        alu_control          = dec.alu_class;
        alu_control[ALU_ADD] = dec.alu_class[ALU_ADD] | force_add;
    end

    // link writes pc + 8, the return point past the delay slot
    assign alu_operand1 = dec.j_link   ? pc
                        : dec.shf_sa   ? {{(XLEN-5){1'b0}}, inst.r.sa}
                        : rs_value;
    assign alu_operand2 = dec.j_link   ? LINK_OFFSET
                        : dec.imm_zero ? {{(XLEN-16){1'b0}}, inst.i.imm}
                        : dec.imm_sign ? {{(XLEN-16){inst.i.imm[15]}}, inst.i.imm}
                        : rt_value;

    // only the trapping add and sub forms
    assign check_overflow = dec.alu_class[ALU_ADD] & (inst.i.op == OP_ADDI)
                          | dec.alu_class[ALU_ADD] & (inst.r.op == OP_SPECIAL)
                                                   & (inst.r.funct == FN_ADD)
                          | dec.alu_class[ALU_SUB] & (inst.r.funct == FN_SUB);

    assign mem_control[MEM_LOAD]  = dec.load;
    assign mem_control[MEM_STORE] = dec.store;
    assign mem_control[MEM_WORD]  = dec.load | dec.store; // only word accesses kept
    assign store_data             = rt_value;

    assign rf_wen   = dec.wdest_rt | dec.wdest_31 | dec.wdest_rd;
    assign rf_wdest = dec.wdest_rt ? inst.i.rt
                    : dec.wdest_31 ? REG_LINK
                    : dec.wdest_rd ? inst.r.rd
                    : 5'd0;                  // 0 keeps hazard compares quiet

endmodule

// ==== hdl/id_stage_reg.sv ====
`timescale 1ns/1ps

module id_stage_reg import isa_pkg::*; #(
    parameter int PC_W = 32
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            in_valid,
    input  logic [PC_W-1:0] in_pc,
    input  logic [PC_W-1:0] in_inst,
    input  logic            id_over,
    output logic            in_ready,
    output logic            valid,
    output logic [PC_W-1:0] pc,
    output inst_word_u      inst
);

    assign in_ready = ~valid | id_over; // empty, or the held one leaves now

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
            pc    <= '0;
            inst  <= '0;                   // decodes as sll r0, harmless
        end else if (in_valid && in_ready) begin
            valid <= 1'b1;
            pc    <= in_pc;
            inst  <= in_inst;
        end else if (id_over) begin
            valid <= 1'b0;
        end
    end

    // a stalled instruction must stay put until it completes
    a_hold_stalled: assert property (@(posedge clk) disable iff (!arst_n)
        valid && !id_over |=> $stable(pc) && $stable(inst));

endmodule

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder import isa_pkg::*; import pipe_pkg::*; (
    input  inst_word_u    inst,
    dec_if.decoder        dec
);

    logic op_zero, sa_zero, rs_zero, rt_zero, rd_zero, r_plain;
    logic i_add, i_addu, i_sub, i_subu, i_slt, i_sltu;
    logic i_and, i_nor, i_or, i_xor;
    logic i_sll, i_srl, i_sra, i_sllv, i_srlv, i_srav;
    logic i_jr, i_jalr;
    logic i_addi, i_addiu, i_slti, i_sltiu, i_andi, i_ori, i_xori, i_lui;
    logic i_lw, i_sw;
    logic i_beq, i_bne, i_bgez, i_bgtz, i_blez, i_bltz, i_bgezal, i_bltzal;
    logic i_j, i_jal;

    assign op_zero = (inst.r.op == OP_SPECIAL);
    assign sa_zero = (inst.r.sa == '0);
    assign rs_zero = (inst.r.rs == '0);
    assign rt_zero = (inst.r.rt == '0);
    assign rd_zero = (inst.r.rd == '0);
    assign r_plain = op_zero & sa_zero;         // register forms with sa unused

    // ***********************************************************
    // register format
    // ***********************************************************
    assign i_add  = r_plain & (inst.r.funct == FN_ADD);
    assign i_addu = r_plain & (inst.r.funct == FN_ADDU);
    assign i_sub  = r_plain & (inst.r.funct == FN_SUB);
    assign i_subu = r_plain & (inst.r.funct == FN_SUBU);
    assign i_slt  = r_plain & (inst.r.funct == FN_SLT);
    assign i_sltu = r_plain & (inst.r.funct == FN_SLTU);
    assign i_and  = r_plain & (inst.r.funct == FN_AND);
    assign i_nor  = r_plain & (inst.r.funct == FN_NOR);
    assign i_or   = r_plain & (inst.r.funct == FN_OR);
    assign i_xor  = r_plain & (inst.r.funct == FN_XOR);
    assign i_sllv = r_plain & (inst.r.funct == FN_SLLV);
    assign i_srlv = r_plain & (inst.r.funct == FN_SRLV);
    assign i_srav = r_plain & (inst.r.funct == FN_SRAV);
    assign i_sll  = op_zero & rs_zero & (inst.r.funct == FN_SLL); // sa holds the shift
    assign i_srl  = op_zero & rs_zero & (inst.r.funct == FN_SRL);
    assign i_sra  = op_zero & rs_zero & (inst.r.funct == FN_SRA);
    assign i_jr   = r_plain & rt_zero & rd_zero & (inst.r.funct == FN_JR);
    assign i_jalr = r_plain & rt_zero & (inst.r.rd == REG_LINK)
                  & (inst.r.funct == FN_JALR);

    // ***********************************************************
    // immediate and jump formats
    // ***********************************************************
    assign i_addi   = (inst.i.op == OP_ADDI);
    assign i_addiu  = (inst.i.op == OP_ADDIU);
    assign i_slti   = (inst.i.op == OP_SLTI);
    assign i_sltiu  = (inst.i.op == OP_SLTIU);
    assign i_andi   = (inst.i.op == OP_ANDI);
    assign i_ori    = (inst.i.op == OP_ORI);
    assign i_xori   = (inst.i.op == OP_XORI);
    assign i_lui    = (inst.i.op == OP_LUI) & rs_zero;
    assign i_lw     = (inst.i.op == OP_LW);
    assign i_sw     = (inst.i.op == OP_SW);
    assign i_beq    = (inst.i.op == OP_BEQ);
    assign i_bne    = (inst.i.op == OP_BNE);
    assign i_bgtz   = (inst.i.op == OP_BGTZ) & rt_zero;
    assign i_blez   = (inst.i.op == OP_BLEZ) & rt_zero;
    assign i_bltz   = (inst.i.op == OP_REGIMM) & (inst.i.rt == RT_BLTZ);
    assign i_bgez   = (inst.i.op == OP_REGIMM) & (inst.i.rt == RT_BGEZ);
    assign i_bltzal = (inst.i.op == OP_REGIMM) & (inst.i.rt == RT_BLTZAL);
    assign i_bgezal = (inst.i.op == OP_REGIMM) & (inst.i.rt == RT_BGEZAL);
    assign i_j      = (inst.j.op == OP_J);
    assign i_jal    = (inst.j.op == OP_JAL);

    // alu classes, loads, stores and links get add forced later
    assign dec.alu_class[ALU_ADD]  = i_add | i_addu | i_addi | i_addiu;
    assign dec.alu_class[ALU_SUB]  = i_sub | i_subu;
    assign dec.alu_class[ALU_SLT]  = i_slt | i_slti;
    assign dec.alu_class[ALU_SLTU] = i_sltu | i_sltiu;
    assign dec.alu_class[ALU_AND]  = i_and | i_andi;
    assign dec.alu_class[ALU_NOR]  = i_nor;
    assign dec.alu_class[ALU_OR]   = i_or | i_ori;
    assign dec.alu_class[ALU_XOR]  = i_xor | i_xori;
    assign dec.alu_class[ALU_SLL]  = i_sll | i_sllv;
    assign dec.alu_class[ALU_SRL]  = i_srl | i_srlv;
    assign dec.alu_class[ALU_SRA]  = i_sra | i_srav;
    assign dec.alu_class[ALU_LUI]  = i_lui;

    assign dec.shf_sa   = i_sll | i_srl | i_sra;
    assign dec.load     = i_lw;
    assign dec.store    = i_sw;
    assign dec.imm_zero = i_andi | i_ori | i_xori | i_lui;
    assign dec.imm_sign = i_addi | i_addiu | i_slti | i_sltiu | i_lw | i_sw;

    assign dec.jr     = i_jr | i_jalr;
    assign dec.j_abs  = i_j | i_jal;
    assign dec.j_link = i_jal | i_jalr | i_bltzal | i_bgezal;
    assign dec.br_eq  = i_beq;
    assign dec.br_ne  = i_bne;
    assign dec.br_gez = i_bgez | i_bgezal;
    assign dec.br_gtz = i_bgtz;
    assign dec.br_lez = i_blez;
    assign dec.br_ltz = i_bltz | i_bltzal;
    assign dec.is_jbr = dec.jr | dec.j_abs | dec.br_eq | dec.br_ne | dec.br_gez
                      | dec.br_gtz | dec.br_lez | dec.br_ltz;

    assign dec.no_rs = i_j | i_jal;             // rs bits belong to the target
    assign dec.no_rt = i_addi | i_addiu | i_slti | i_sltiu | i_lw | dec.imm_zero
                     | dec.j_abs | dec.br_gez | dec.br_ltz;

    assign dec.wdest_rt = dec.imm_zero | i_addi | i_addiu | i_slti | i_sltiu | i_lw;
    assign dec.wdest_31 = i_jal | i_bltzal | i_bgezal;
    assign dec.wdest_rd = i_add | i_addu | i_sub | i_subu | i_slt | i_sltu
                        | i_and | i_nor | i_or | i_xor | i_jalr
                        | i_sll | i_srl | i_sra | i_sllv | i_srlv | i_srav;

    a_class_onehot: assert final ($onehot0(dec.alu_class));

endmodule

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

    typedef logic [4:0] reg_addr_t;
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // ***********************************************************
    // instruction word views
    // ***********************************************************
    typedef struct packed {
        opcode_t   op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] sa;
        funct_t    funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_t     op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;    // immediate or branch offset
    } i_fmt_t;

    typedef struct packed {
        opcode_t     op;
        logic [25:0] target; // word index inside the 256 MB region
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } inst_word_u;

    // ***********************************************************
    // opcodes
    // ***********************************************************
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_REGIMM  = 6'h01;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_BLEZ    = 6'h06;
    localparam opcode_t OP_BGTZ    = 6'h07;
    localparam opcode_t OP_ADDI    = 6'h08;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_SLTIU   = 6'h0b;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    // function codes under OP_SPECIAL
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_SRA  = 6'h03;
    localparam funct_t FN_SLLV = 6'h04;
    localparam funct_t FN_SRLV = 6'h06;
    localparam funct_t FN_SRAV = 6'h07;
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_JALR = 6'h09;
    localparam funct_t FN_ADD  = 6'h20;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUB  = 6'h22;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;
    localparam funct_t FN_SLTU = 6'h2b;

    // rt selects the branch under OP_REGIMM
    localparam reg_addr_t RT_BLTZ   = 5'd0;
    localparam reg_addr_t RT_BGEZ   = 5'd1;
    localparam reg_addr_t RT_BLTZAL = 5'd16;
    localparam reg_addr_t RT_BGEZAL = 5'd17;

    localparam reg_addr_t REG_LINK = 5'd31;

endpackage

// ==== hdl/issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl import isa_pkg::*; #(
    parameter int N_WB_STAGES = 3
) (
    input  logic                            valid,
    input  logic                            if_over,
    input  inst_word_u                      inst,
    input  reg_addr_t [N_WB_STAGES-1:0]     wdest,   // 0 means no write
    dec_if.hazard                           dec,
    output logic                            rs_wait,
    output logic                            rt_wait,
    output logic                            id_over
);

    logic rs_hit, rt_hit;

    always_comb begin
        rs_hit = 1'b0;
        rt_hit = 1'b0;
        for (int k = 0; k < N_WB_STAGES; k++) begin
            rs_hit = rs_hit | (inst.r.rs == wdest[k]);
            rt_hit = rt_hit | (inst.r.rt == wdest[k]);
        end
    end

    assign rs_wait = ~dec.no_rs & (inst.r.rs != '0) & rs_hit;
    assign rt_wait = ~dec.no_rt & (inst.r.rt != '0) & rt_hit;

    // a jump must not finish before fetch can take its target
    assign id_over = valid & ~rs_wait & ~rt_wait & (~dec.is_jbr | if_over);

    a_no_over_on_wait: assert final (!(id_over && (rs_wait || rt_wait)));

endmodule

// ==== hdl/pipe_pkg.sv ====
package pipe_pkg;

    localparam int XLEN    = 32;
    localparam int ALU_OPS = 12;

    // one-hot alu class positions, add on top
    localparam int ALU_ADD  = 11;
    localparam int ALU_SUB  = 10;
    localparam int ALU_SLT  = 9;
    localparam int ALU_SLTU = 8;
    localparam int ALU_AND  = 7;
    localparam int ALU_NOR  = 6;
    localparam int ALU_OR   = 5;
    localparam int ALU_XOR  = 4;
    localparam int ALU_SLL  = 3;
    localparam int ALU_SRL  = 2;
    localparam int ALU_SRA  = 1;
    localparam int ALU_LUI  = 0;

    localparam logic [XLEN-1:0] LINK_OFFSET = 8; // return past the delay slot
    localparam logic [XLEN-1:0] INST_BYTES  = 4;

    // memory control is {load, store, word}
    localparam int MEM_CTRL_W = 3;
    localparam int MEM_LOAD   = 2;
    localparam int MEM_STORE  = 1;
    localparam int MEM_WORD   = 0;

endpackage
